/* build.f */
+incdir+sim
hdl/issue_pkg.sv
hdl/int_regfile.sv
hdl/hazard_check.sv
hdl/operand_mux.sv
hdl/unit_dispatch.sv
hdl/issue_read_operands.sv
sim/tb_issue_read_operands.sv

/* Bender.yml */
package:
  name: issue_read_operands

sources:
  - hdl/issue_pkg.sv
  - hdl/int_regfile.sv
  - hdl/hazard_check.sv
  - hdl/operand_mux.sv
  - hdl/unit_dispatch.sv
  - hdl/issue_read_operands.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_issue_read_operands.sv

/* sim/tb_model.svh */
// LFSR random source, register file model, counters and the value check of the testbench
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam logic [15:0] SEED = 16'd51208;

logic [15:0]                lfsr_q = SEED;
logic [issue_pkg::XLEN-1:0] model_regs [issue_pkg::NR_REGS];
int unsigned                error_count = 0;
int unsigned                test_errors = 0;
int unsigned                check_count = 0;

// ----------------------------------------
// random source
// ----------------------------------------
// 16 bit fibonacci lfsr, taps 16 14 13 11, one step per bit
function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
endfunction

function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_bit()};
    end
    return v;
endfunction

// x0 reads as zero whatever was written
function automatic logic [issue_pkg::XLEN-1:0] model_read(
    input logic [issue_pkg::REG_ADDR_BITS-1:0] addr);
    return (addr == '0) ? '0 : model_regs[addr];
endfunction

// ----------------------------------------
// value check
// ----------------------------------------
task automatic check_value(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
    check_count++;
    if (got !== exp) begin
        $display("** Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        error_count++;
        test_errors++;
    end
endtask

`endif

/* sim/tb_issue_read_operands.sv */
// testbench of the issue stage: clock, reset, random stimulus, reference model and reporting
`timescale 1ns/100ps

module tb_issue_read_operands;

    // random issue cycles over all tests, split evenly between the tests
    localparam int unsigned N_TESTS        = 600;
    localparam int unsigned N_PHASES       = 6;
    localparam int unsigned TIMEOUT_MARGIN = 50;
    localparam int unsigned CYCLE_LIMIT    = N_TESTS + 2 + TIMEOUT_MARGIN;

    logic                                                   clk_i = 1'b0;
    logic                                                   rst_ni;
    logic                                                   flush_i;
    issue_pkg::issue_entry_t                                issue_entry;
    logic                                                   issue_valid;
    logic                                                   issue_ack;
    issue_pkg::clobber_t                                    clobber;
    logic [issue_pkg::REG_ADDR_BITS-1:0]                    rs1_idx;
    logic [issue_pkg::REG_ADDR_BITS-1:0]                    rs2_idx;
    issue_pkg::sb_operand_t                                 rs1_sb;
    issue_pkg::sb_operand_t                                 rs2_sb;
    logic                                                   flu_ready;
    logic                                                   lsu_ready;
    issue_pkg::commit_port_t [issue_pkg::NR_COMMIT_PORTS-1:0] commit;
    issue_pkg::fu_data_t                                    fu_data;
    issue_pkg::unit_valid_t                                 unit_valid;
    logic [issue_pkg::XLEN-1:0]                             rs1_fwd;
    logic [issue_pkg::XLEN-1:0]                             rs2_fwd;

    // model expectation for the registered outputs after the next edge
    issue_pkg::fu_data_t    exp_fu_data;
    issue_pkg::unit_valid_t exp_valid;
    int unsigned            cycle_count = 0;

    `include "tb_model.svh"

    issue_read_operands DUT (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .issue_entry_i (issue_entry),
        .issue_valid_i (issue_valid),
        .issue_ack_o   (issue_ack),
        .clobber_i     (clobber),
        .rs1_o         (rs1_idx),
        .rs2_o         (rs2_idx),
        .rs1_i         (rs1_sb),
        .rs2_i         (rs2_sb),
        .flu_ready_i   (flu_ready),
        .lsu_ready_i   (lsu_ready),
        .commit_i      (commit),
        .fu_data_o     (fu_data),
        .unit_valid_o  (unit_valid),
        .rs1_fwd_o     (rs1_fwd),
        .rs2_fwd_o     (rs2_fwd)
    );

    always #2 clk_i = ~clk_i;

    // run limit, a few cycles beyond the stimulus length
    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic issue_pkg::fu_t pick_fu();
        return issue_pkg::fu_t'(3'(rand_bits(3) % 7));
    endfunction

    function automatic string test_name(input int unsigned t);
        case (t)
            0:       return "register file";
            1:       return "forward or stall";
            2:       return "acknowledge rules";
            3:       return "operand selection";
            4:       return "multiplier lock";
            default: return "flush";
        endcase
    endfunction

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    // each test biases the random fields towards its behavior
    task automatic drive_inputs(input int unsigned t);
        issue_pkg::issue_entry_t e;
        e.rs1      = 5'(rand_bits(5));
        e.rs2      = 5'(rand_bits(5));
        e.rd       = 5'(rand_bits(5));
        e.imm      = rand_bits(32);
        e.pc       = rand_bits(32);
        e.trans_id = 3'(rand_bits(3));
        e.fu       = (t == 4 && lfsr_bit()) ? issue_pkg::FU_MULT : pick_fu();
        e.op       = issue_pkg::fu_op_t'(4'(rand_bits(4) % 14));
        if (t == 1 && lfsr_bit()) begin
            e.op = issue_pkg::OP_SFENCE_VMA;
        end
        e.use_imm  = (t == 3) ? lfsr_bit() : 1'b0;
        e.use_pc   = (t == 3) ? lfsr_bit() : 1'b0;
        e.use_zimm = (t == 3) ? lfsr_bit() : 1'b0;
        e.ex_valid = (t == 2) ? (rand_bits(2) == 0) : 1'b0;
        issue_entry = e;
        // dense clobbers for forwarding, none for register file and mult tests
        for (int unsigned r = 0; r < issue_pkg::NR_REGS; r++) begin
            if (t == 0 || t == 4) begin
                clobber[r] = issue_pkg::FU_NONE;
            end else begin
                clobber[r] = (rand_bits(t == 1 ? 1 : 2) == 0) ? pick_fu() : issue_pkg::FU_NONE;
            end
        end
        rs1_sb.value = rand_bits(32);
        rs1_sb.valid = (t == 1) ? lfsr_bit() : (rand_bits(2) != 0);
        rs2_sb.value = rand_bits(32);
        rs2_sb.valid = (t == 1) ? lfsr_bit() : (rand_bits(2) != 0);
        issue_valid  = (t == 2) ? lfsr_bit() : (rand_bits(3) != 0);
        flu_ready    = (t == 2) ? lfsr_bit() : 1'b1;
        lsu_ready    = (t == 2) ? lfsr_bit() : 1'b1;
        flush_i      = (t == 5) ? lfsr_bit() : 1'b0;
        for (int unsigned p = 0; p < issue_pkg::NR_COMMIT_PORTS; p++) begin
            commit[p].waddr = 5'(rand_bits(5));
            commit[p].wdata = rand_bits(32);
            commit[p].we    = (t == 0) ? (rand_bits(2) != 0) : lfsr_bit();
        end
    endtask

    // ----------------------------------------
    // reference model and checks
    // ----------------------------------------
    task automatic check_registered();
        check_value("fu_data_o", fu_data, exp_fu_data);
        check_value("unit_valid_o", unit_valid, exp_valid);
    endtask

    task automatic check_issue();
        issue_pkg::fu_t         c1;
        issue_pkg::fu_t         c2;
        logic                   sfence;
        logic                   need1;
        logic                   need2;
        logic                   fwd1;
        logic                   fwd2;
        logic                   busy;
        logic                   rd_free;
        logic                   ack;
        logic                   launch;
        logic [31:0]            op_a;
        logic [31:0]            op_b;
        issue_pkg::unit_valid_t nv;
        c1     = clobber[issue_entry.rs1];
        c2     = clobber[issue_entry.rs2];
        sfence = (issue_entry.op == issue_pkg::OP_SFENCE_VMA);
        // a clobbered source needs a valid scoreboard value, CSR ones only for sfence.vma
        need1  = !issue_entry.use_zimm && (c1 != issue_pkg::FU_NONE);
        need2  = (c2 != issue_pkg::FU_NONE);
        fwd1   = need1 && rs1_sb.valid && ((c1 != issue_pkg::FU_CSR) || sfence);
        fwd2   = need2 && rs2_sb.valid && ((c2 != issue_pkg::FU_CSR) || sfence);
        case (issue_entry.fu)
            issue_pkg::FU_NONE:                      busy = 1'b0;
            issue_pkg::FU_LOAD, issue_pkg::FU_STORE: busy = !lsu_ready;
            default:                                 busy = !flu_ready;
        endcase
        rd_free = (clobber[issue_entry.rd] == issue_pkg::FU_NONE);
        for (int unsigned p = 0; p < issue_pkg::NR_COMMIT_PORTS; p++) begin
            rd_free = rd_free || (commit[p].we && commit[p].waddr == issue_entry.rd);
        end
        // lock is the mult strobe that the previous cycle produced
        ack = issue_valid && ((!(need1 && !fwd1) && !(need2 && !fwd2) && !busy && rd_free)
              || issue_entry.ex_valid || (issue_entry.fu == issue_pkg::FU_NONE))
              && (!exp_valid.mult || (issue_entry.fu == issue_pkg::FU_MULT));
        launch = ack && !issue_entry.ex_valid;
        op_a = fwd1 ? rs1_sb.value : model_read(issue_entry.rs1);
        op_b = fwd2 ? rs2_sb.value : model_read(issue_entry.rs2);
        if (issue_entry.use_pc) begin
            op_a = issue_entry.pc;
        end
        if (issue_entry.use_zimm) begin
            op_a = 32'(issue_entry.rs1);
        end
        if (issue_entry.use_imm && issue_entry.fu != issue_pkg::FU_STORE
            && issue_entry.fu != issue_pkg::FU_CTRL_FLOW) begin
            op_b = issue_entry.imm;
        end
        check_value("issue_ack_o", issue_ack, ack);
        check_value("rs1_o", rs1_idx, issue_entry.rs1);
        check_value("rs2_o", rs2_idx, issue_entry.rs2);
        check_value("rs1_fwd_o", rs1_fwd, op_a);
        check_value("rs2_fwd_o", rs2_fwd, op_b);
        exp_fu_data = '{fu: issue_entry.fu, op: issue_entry.op, operand_a: op_a,
                        operand_b: op_b, imm: issue_entry.imm, trans_id: issue_entry.trans_id};
        nv = '0;
        if (launch && !flush_i) begin
            case (issue_entry.fu)
                issue_pkg::FU_ALU:                       nv.alu    = 1'b1;
                issue_pkg::FU_CTRL_FLOW:                 nv.branch = 1'b1;
                issue_pkg::FU_LOAD, issue_pkg::FU_STORE: nv.lsu    = 1'b1;
                issue_pkg::FU_MULT:                      nv.mult   = 1'b1;
                issue_pkg::FU_CSR:                       nv.csr    = 1'b1;
                default:                                 nv        = '0;
            endcase
        end
        exp_valid = nv;
        // commits land at the coming edge, higher port last
        for (int unsigned p = 0; p < issue_pkg::NR_COMMIT_PORTS; p++) begin
            if (commit[p].we && commit[p].waddr != '0) begin
                model_regs[commit[p].waddr] = commit[p].wdata;
            end
        end
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        rst_ni      = 1'b0;
        flush_i     = 1'b0;
        issue_entry = '0;
        issue_valid = 1'b0;
        clobber     = '0;
        rs1_sb      = '0;
        rs2_sb      = '0;
        flu_ready   = 1'b0;
        lsu_ready   = 1'b0;
        commit      = '0;
        exp_fu_data = '0;
        exp_valid   = '0;
        for (int unsigned r = 0; r < issue_pkg::NR_REGS; r++) begin
            model_regs[r] = '0;
        end
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        for (int unsigned t = 0; t < N_PHASES; t++) begin
            test_errors = 0;
            for (int unsigned c = 0; c < N_TESTS / N_PHASES; c++) begin
                check_registered();
                drive_inputs(t);
                #1;
                check_issue();
                @(negedge clk_i);
            end
            $display("test %0d %s: %0d cycles, %0d errors", t, test_name(t),
                     N_TESTS / N_PHASES, test_errors);
        end
        check_registered();
        $display("tests %0d, checks %0d, errors %0d", N_PHASES, check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* hdl/issue_read_operands.sv */
// top of the integer issue and operand-read stage
`timescale 1ns/100ps

module issue_read_operands (
    input  logic                                                  clk_i,
    input  logic                                                  rst_ni,
    input  logic                                                  flush_i,
    // scoreboard side
    input  issue_pkg::issue_entry_t                               issue_entry_i,
    input  logic                                                  issue_valid_i,
    output logic                                                  issue_ack_o,
    input  issue_pkg::clobber_t                                   clobber_i,
    output logic [issue_pkg::REG_ADDR_BITS-1:0]                   rs1_o,
    output logic [issue_pkg::REG_ADDR_BITS-1:0]                   rs2_o,
    input  issue_pkg::sb_operand_t                                rs1_i,
    input  issue_pkg::sb_operand_t                                rs2_i,
    // unit readiness
    input  logic                                                  flu_ready_i,
    input  logic                                                  lsu_ready_i,
    // commit write ports
    input  issue_pkg::commit_port_t [issue_pkg::NR_COMMIT_PORTS-1:0] commit_i,
    // execute side
    output issue_pkg::fu_data_t                                   fu_data_o,
    output issue_pkg::unit_valid_t                                unit_valid_o,
    output logic [issue_pkg::XLEN-1:0]                            rs1_fwd_o,
    output logic [issue_pkg::XLEN-1:0]                            rs2_fwd_o
);

    issue_pkg::fwd_sel_t        fwd_sel;
    logic                       launch;
    logic                       mult_lock;
    logic [issue_pkg::XLEN-1:0] rdata_a;
    logic [issue_pkg::XLEN-1:0] rdata_b;

    // ----------------------------------------
    // issue decision
    // ----------------------------------------
    hazard_check i_hazard_check (
        .issue_entry_i (issue_entry_i),
        .issue_valid_i (issue_valid_i),
        .clobber_i     (clobber_i),
        .rs1_valid_i   (rs1_i.valid),
        .rs2_valid_i   (rs2_i.valid),
        .flu_ready_i   (flu_ready_i),
        .lsu_ready_i   (lsu_ready_i),
        .commit_i      (commit_i),
        .mult_lock_i   (mult_lock),
        .issue_ack_o   (issue_ack_o),
        .launch_o      (launch),
        .fwd_sel_o     (fwd_sel),
        .rs1_o         (rs1_o),
        .rs2_o         (rs2_o)
    );

    // read ports follow the entry sources directly
    int_regfile i_int_regfile (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .raddr_a_i (issue_entry_i.rs1),
        .raddr_b_i (issue_entry_i.rs2),
        .commit_i  (commit_i),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b)
    );

    // ----------------------------------------
    // operands and dispatch
    // ----------------------------------------
    operand_mux i_operand_mux (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .issue_entry_i (issue_entry_i),
        .fwd_sel_i     (fwd_sel),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .rdata_a_i     (rdata_a),
        .rdata_b_i     (rdata_b),
        .fu_data_o     (fu_data_o),
        .rs1_fwd_o     (rs1_fwd_o),
        .rs2_fwd_o     (rs2_fwd_o)
    );

    unit_dispatch i_unit_dispatch (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .launch_i     (launch),
        .fu_i         (issue_entry_i.fu),
        .unit_valid_o (unit_valid_o),
        .mult_lock_o  (mult_lock)
    );

endmodule

/* hdl/unit_dispatch.sv */
// registered per-unit valid strobes with flush, and the multiplier lock
`timescale 1ns/100ps

module unit_dispatch (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  logic                    launch_i,
    input  issue_pkg::fu_t          fu_i,
    output issue_pkg::unit_valid_t  unit_valid_o,
    output logic                    mult_lock_o
);

    issue_pkg::unit_valid_t valid_q;

    // ----------------------------------------
    // valid strobes
    // ----------------------------------------
    // every strobe lasts one cycle, a launch sets the one matching fu_i
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            valid_q <= '0;
            // a flush drops the launch, the unit would see stale operands
            if (launch_i && !flush_i) begin
                case (fu_i)
                    issue_pkg::FU_ALU: begin
                        valid_q.alu <= 1'b1;
                    end
                    issue_pkg::FU_CTRL_FLOW: begin
                        valid_q.branch <= 1'b1;
                    end
                    // loads and stores share the lsu
                    issue_pkg::FU_LOAD, issue_pkg::FU_STORE: begin
                        valid_q.lsu <= 1'b1;
                    end
                    issue_pkg::FU_MULT: begin
                        valid_q.mult <= 1'b1;
                    end
                    issue_pkg::FU_CSR: begin
                        valid_q.csr <= 1'b1;
                    end
                    // FU_NONE has no unit to start
                    default: begin
                    end
                endcase
            end
        end
    end

    assign unit_valid_o = valid_q;

    // a registered mult blocks non-mult issue for one cycle
    assign mult_lock_o = valid_q.mult;

    // a strobe names one unit and follows an unflushed launch
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (|unit_valid_o) |-> $onehot(unit_valid_o) && $past(launch_i && !flush_i))
        else $error("unit valid strobe without a single matching launch");

endmodule

/* hdl/operand_mux.sv */
// operand source selection and the issue to execute pipeline register
`timescale 1ns/100ps

module operand_mux (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  issue_pkg::issue_entry_t     issue_entry_i,
    input  issue_pkg::fwd_sel_t         fwd_sel_i,
    input  issue_pkg::sb_operand_t      rs1_i,
    input  issue_pkg::sb_operand_t      rs2_i,
    input  logic [issue_pkg::XLEN-1:0]  rdata_a_i,
    input  logic [issue_pkg::XLEN-1:0]  rdata_b_i,
    output issue_pkg::fu_data_t         fu_data_o,
    output logic [issue_pkg::XLEN-1:0]  rs1_fwd_o,
    output logic [issue_pkg::XLEN-1:0]  rs2_fwd_o
);

    logic [issue_pkg::XLEN-1:0] operand_a_n;
    logic [issue_pkg::XLEN-1:0] operand_b_n;
    logic                       imm_to_b;

    // stores and branches keep rs2, their immediate travels in imm
    assign imm_to_b = issue_entry_i.use_imm
                      && (issue_entry_i.fu != issue_pkg::FU_STORE)
                      && (issue_entry_i.fu != issue_pkg::FU_CTRL_FLOW);

    // ----------------------------------------
    // operand select
    // ----------------------------------------
    // later checks override earlier ones
    always_comb begin : operand_select
        operand_a_n = fwd_sel_i.rs1 ? rs1_i.value : rdata_a_i;
        operand_b_n = fwd_sel_i.rs2 ? rs2_i.value : rdata_b_i;
        if (issue_entry_i.use_pc) begin
            operand_a_n = issue_entry_i.pc;
        end
        // zimm is the rs1 field, zero extended
        if (issue_entry_i.use_zimm) begin
            operand_a_n = {{(issue_pkg::XLEN-issue_pkg::REG_ADDR_BITS){1'b0}}, issue_entry_i.rs1};
        end
        if (imm_to_b) begin
            operand_b_n = issue_entry_i.imm;
        end
    end

    // unregistered copies for early consumers
    assign rs1_fwd_o = operand_a_n;
    assign rs2_fwd_o = operand_b_n;

    // ----------------------------------------
    // issue to execute register
    // ----------------------------------------
    // loads every cycle, only meaningful under a unit valid
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fu_data_o <= '{fu: issue_pkg::FU_NONE, op: issue_pkg::OP_ADD, default: '0};
        end else begin
            fu_data_o.fu        <= issue_entry_i.fu;
            fu_data_o.op        <= issue_entry_i.op;
            fu_data_o.operand_a <= operand_a_n;
            fu_data_o.operand_b <= operand_b_n;
            fu_data_o.imm       <= issue_entry_i.imm;
            fu_data_o.trans_id  <= issue_entry_i.trans_id;
        end
    end

endmodule

/* hdl/hazard_check.sv */
// clobber lookup, forward or stall per source, unit busy, WAW check and issue acknowledge
`timescale 1ns/100ps

module hazard_check (
    input  issue_pkg::issue_entry_t                               issue_entry_i,
    input  logic                                                  issue_valid_i,
    input  issue_pkg::clobber_t                                   clobber_i,
    input  logic                                                  rs1_valid_i,
    input  logic                                                  rs2_valid_i,
    input  logic                                                  flu_ready_i,
    input  logic                                                  lsu_ready_i,
    input  issue_pkg::commit_port_t [issue_pkg::NR_COMMIT_PORTS-1:0] commit_i,
    input  logic                                                  mult_lock_i,
    output logic                                                  issue_ack_o,
    output logic                                                  launch_o,
    output issue_pkg::fwd_sel_t                                   fwd_sel_o,
    output logic [issue_pkg::REG_ADDR_BITS-1:0]                   rs1_o,
    output logic [issue_pkg::REG_ADDR_BITS-1:0]                   rs2_o
);

    issue_pkg::fu_t clob_rs1;
    issue_pkg::fu_t clob_rs2;
    issue_pkg::fu_t clob_rd;
    logic           is_sfence;
    logic           stall;
    logic           fu_busy;
    logic           rd_free;

    // scoreboard lookup of the source values
    assign rs1_o = issue_entry_i.rs1;
    assign rs2_o = issue_entry_i.rs2;

    assign clob_rs1  = clobber_i[issue_entry_i.rs1];
    assign clob_rs2  = clobber_i[issue_entry_i.rs2];
    assign clob_rd   = clobber_i[issue_entry_i.rd];
    // sfence.vma may take a CSR result from the scoreboard
    assign is_sfence = (issue_entry_i.op == issue_pkg::OP_SFENCE_VMA);

    // ----------------------------------------
    // operand availability
    // ----------------------------------------
    always_comb begin : operand_check
        stall     = 1'b0;
        fwd_sel_o = '0;
        // zimm carries an immediate in rs1, nothing to wait on
        if (!issue_entry_i.use_zimm && (clob_rs1 != issue_pkg::FU_NONE)) begin
            // CSR results only reach us through the register file
            if (rs1_valid_i && ((clob_rs1 != issue_pkg::FU_CSR) || is_sfence)) begin
                fwd_sel_o.rs1 = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
        if (clob_rs2 != issue_pkg::FU_NONE) begin
            if (rs2_valid_i && ((clob_rs2 != issue_pkg::FU_CSR) || is_sfence)) begin
                fwd_sel_o.rs2 = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
    end

    // busy signal of the unit this instruction needs
    always_comb begin : unit_busy
        case (issue_entry_i.fu)
            issue_pkg::FU_ALU, issue_pkg::FU_CTRL_FLOW,
            issue_pkg::FU_CSR, issue_pkg::FU_MULT:  fu_busy = ~flu_ready_i;
            issue_pkg::FU_LOAD, issue_pkg::FU_STORE: fu_busy = ~lsu_ready_i;
            default:                                 fu_busy = 1'b0;
        endcase
    end

    // ----------------------------------------
    // WAW check and acknowledge
    // ----------------------------------------
    // rd is free when unclobbered or written back by commit in this cycle
    always_comb begin : waw_check
        rd_free = (clob_rd == issue_pkg::FU_NONE);
        for (int unsigned p = 0; p < issue_pkg::NR_COMMIT_PORTS; p++) begin
            if (commit_i[p].we && (commit_i[p].waddr == issue_entry_i.rd)) begin
                rd_free = 1'b1;
            end
        end
    end

    always_comb begin : issue_ack
        issue_ack_o = 1'b0;
        if (issue_valid_i) begin
            if (!stall && !fu_busy && rd_free) begin
                issue_ack_o = 1'b1;
            end
            // exceptions and unit-less instructions just pass through
            if (issue_entry_i.ex_valid || (issue_entry_i.fu == issue_pkg::FU_NONE)) begin
                issue_ack_o = 1'b1;
            end
        end
        // one cycle after a mult only another mult may go, the result bus is shared
        if (mult_lock_i && (issue_entry_i.fu != issue_pkg::FU_MULT)) begin
            issue_ack_o = 1'b0;
        end
    end

    assign launch_o = issue_valid_i & issue_ack_o & ~issue_entry_i.ex_valid;

endmodule

/* hdl/int_regfile.sv */
// integer register file, two read ports and one write port per commit port
`timescale 1ns/100ps

module int_regfile (
    input  logic                                                  clk_i,
    input  logic                                                  rst_ni,
    input  logic [issue_pkg::REG_ADDR_BITS-1:0]                   raddr_a_i,
    input  logic [issue_pkg::REG_ADDR_BITS-1:0]                   raddr_b_i,
    input  issue_pkg::commit_port_t [issue_pkg::NR_COMMIT_PORTS-1:0] commit_i,
    output logic [issue_pkg::XLEN-1:0]                            rdata_a_o,
    output logic [issue_pkg::XLEN-1:0]                            rdata_b_o
);

    // register array, entry 0 is never written
    logic [issue_pkg::NR_REGS-1:0][issue_pkg::XLEN-1:0] mem_q;

    // ----------------------------------------
    // write ports
    // ----------------------------------------
    // ports applied in order, so the highest port wins on the same address
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mem_q <= '0;
        end else begin
            for (int unsigned p = 0; p < issue_pkg::NR_COMMIT_PORTS; p++) begin
                if (commit_i[p].we && (commit_i[p].waddr != '0)) begin
                    mem_q[commit_i[p].waddr] <= commit_i[p].wdata;
                end
            end
        end
    end

    // ----------------------------------------
    // read ports
    // ----------------------------------------
    // no write-to-read bypass, the scoreboard forward covers that cycle
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : mem_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : mem_q[raddr_b_i];

    // read addresses come straight from the scoreboard entry
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        !$isunknown({raddr_a_i, raddr_b_i}))
        else $error("unknown register file read address");

endmodule

/* hdl/issue_pkg.sv */
// widths, unit and operation enums, and packed structs of the integer issue stage
package issue_pkg;

    // ----------------------------------------
    // widths and sizes
    // ----------------------------------------
    localparam int unsigned XLEN            = 32;
    localparam int unsigned REG_ADDR_BITS   = 5;
    localparam int unsigned NR_REGS         = 32;
    localparam int unsigned TRANS_ID_BITS   = 3;
    localparam int unsigned NR_COMMIT_PORTS = 2;

    // functional unit that executes an instruction
    // FU_NONE must stay at zero, the stage registers reset to it
    typedef enum logic [2:0] {
        FU_NONE      = 3'd0,
        FU_ALU       = 3'd1,
        FU_CTRL_FLOW = 3'd2,
        FU_LOAD      = 3'd3,
        FU_STORE     = 3'd4,
        FU_MULT      = 3'd5,
        FU_CSR       = 3'd6
    } fu_t;

    // operation code, opaque to this stage apart from sfence.vma
    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL,
        OP_BEQ, OP_BNE, OP_LW, OP_SW, OP_MUL, OP_CSRRW, OP_SFENCE_VMA
    } fu_op_t;

    // ----------------------------------------
    // structs
    // ----------------------------------------
    // decoded instruction from the scoreboard
    typedef struct packed {
        logic [REG_ADDR_BITS-1:0] rs1;
        logic [REG_ADDR_BITS-1:0] rs2;
        logic [REG_ADDR_BITS-1:0] rd;
        logic [XLEN-1:0]          imm;
        logic [XLEN-1:0]          pc;
        logic [TRANS_ID_BITS-1:0] trans_id;
        fu_t                      fu;
        fu_op_t                   op;
        logic                     use_imm;
        logic                     use_pc;
        logic                     use_zimm;
        // exception already raised upstream
        logic                     ex_valid;
    } issue_entry_t;

    // per register, the unit that will write it, FU_NONE when nobody does
    typedef fu_t [NR_REGS-1:0] clobber_t;

    typedef struct packed {
        logic [XLEN-1:0] value;
        logic            valid;
    } sb_operand_t;

    typedef struct packed {
        logic [REG_ADDR_BITS-1:0] waddr;
        logic [XLEN-1:0]          wdata;
        logic                     we;
    } commit_port_t;

    // operands and control handed to execute
    typedef struct packed {
        fu_t                      fu;
        fu_op_t                   op;
        logic [XLEN-1:0]          operand_a;
        logic [XLEN-1:0]          operand_b;
        logic [XLEN-1:0]          imm;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

    typedef struct packed {
        logic alu;
        logic branch;
        logic lsu;
        logic mult;
        logic csr;
    } unit_valid_t;

    typedef struct packed {
        logic rs1;
        logic rs2;
    } fwd_sel_t;

endpackage
